// File: rtl/fetch_pkg.sv
package fetch_pkg;

	// ==============================
	// Fetch side types
	// ==============================

	// Byte address as seen by the fetch unit
	typedef logic [31:0] address_t;

	// One half-line of instruction bytes, 16 bytes wide
	typedef logic [127:0] half_line_t;

	// A half-line as handed to the decoder
	// The address is always half-line aligned and rebuilt from the fetch address
	typedef struct packed {
		logic       v;
		address_t   adr;
		half_line_t data;
	} line_out_t;

	// Registered answer to one fetch
	// Lo is the half-line holding the fetch address, hi is the one after it
	typedef struct packed {
		logic      hit;
		address_t  adr;
		line_out_t lo;
		line_out_t hi;
	} fetch_rsp_t;

endpackage

// File: rtl/cache_maint_pkg.sv
package cache_maint_pkg;

	// ==============================
	// Maintenance commands
	// ==============================

	// Invalidate opcode, INV_LINE acts on one set in one bank
	typedef enum logic [1:0] {
		INV_NONE = 2'd0,
		INV_LINE = 2'd1,
		INV_ALL  = 2'd2
	} inv_op_e;

	typedef struct packed {
		inv_op_e            op;
		fetch_pkg::address_t adr;
	} inv_cmd_t;

	// Refill write of one half-line; the way width covers four ways
	typedef struct packed {
		logic                  wr;
		logic [1:0]            way;
		fetch_pkg::address_t   adr;
		fetch_pkg::half_line_t data;
	} fill_t;

	// Store seen on the bus from some core, cid says which one
	typedef struct packed {
		logic                v;
		fetch_pkg::address_t adr;
		logic [5:0]          cid;
	} snoop_t;

endpackage

// File: rtl/line_sram.sv
`timescale 1ns/1ps

module line_sram #(
	parameter int WID = 128,
	parameter int DEP = 64,
	localparam int AW = $clog2(DEP)
) (
	input  logic           clk,
	input  logic           ce_i,
	input  logic           wr_i,
	input  logic [AW-1:0]  wadr_i,
	input  logic [AW-1:0]  radr_i,
	input  logic [WID-1:0] wdata_i,
	output logic [WID-1:0] rdata_o
);

	// Data words, addressed as {way, set}
	logic [WID-1:0] mem [DEP];
	logic [AW-1:0]  radr_q;

	// Refill writes land whatever the state of the clock enable
	always_ff @(posedge clk) begin
		if (wr_i)
			mem[wadr_i] <= wdata_i;
	end

	// Read address is captured only on enabled cycles so the output holds
	always_ff @(posedge clk) begin
		if (ce_i)
			radr_q <= radr_i;
	end

	assign rdata_o = mem[radr_q];

endmodule

// File: rtl/tag_array.sv
`timescale 1ns/1ps

module tag_array #(
	parameter int WAYS  = 4,
	parameter int LINES = 16,
	parameter int LOBIT = 5,
	localparam int WAYW  = $clog2(WAYS),
	localparam int NDXW  = $clog2(LINES),
	localparam int HIBIT = LOBIT + NDXW - 1,
	localparam int TAGW  = $bits(fetch_pkg::address_t) - HIBIT - 1
) (
	input  logic                       clk,
	input  logic                       wr_i,
	input  logic [WAYW-1:0]            way_i,
	input  fetch_pkg::address_t        wadr_i,
	input  logic [NDXW-1:0]            ndx_i,
	input  logic [NDXW-1:0]            sndx_i,
	output logic [WAYS-1:0][TAGW-1:0]  tags_o,
	output logic [WAYS-1:0][TAGW-1:0]  stags_o
);
	import fetch_pkg::*;

	localparam int AW = $bits(address_t);

	// ==============================
	// Tag storage
	// ==============================

	// One tag per way and set, no reset since the valid bits gate every use
	logic [TAGW-1:0] tags [WAYS][LINES];

	logic [NDXW-1:0] wndx;
	logic [TAGW-1:0] wtag;

	// The refill address carries both the set and the tag to store
	assign wndx = wadr_i[HIBIT:LOBIT];
	assign wtag = wadr_i[AW-1:HIBIT+1];

	always_ff @(posedge clk) begin
		if (wr_i)
			tags[way_i][wndx] <= wtag;
	end

	// ==============================
	// Read ports
	// ==============================

	// Lookup port for fetches and snoop port for coherence, both unclocked
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			tags_o[w]  = tags[w][ndx_i];
			stags_o[w] = tags[w][sndx_i];
		end
	end

endmodule

// File: rtl/way_hit.sv
`timescale 1ns/1ps

module way_hit #(
	parameter int WAYS  = 4,
	parameter int LINES = 16,
	parameter int LOBIT = 5,
	localparam int WAYW  = $clog2(WAYS),
	localparam int HIBIT = LOBIT + $clog2(LINES) - 1,
	localparam int TAGW  = $bits(fetch_pkg::address_t) - HIBIT - 1
) (
	input  logic                      clk,
	input  logic                      ce_i,
	input  fetch_pkg::address_t       adr_i,
	input  logic [WAYS-1:0][TAGW-1:0] tags_i,
	input  logic [WAYS-1:0]           valid_i,
	output logic                      hit_o,
	output logic [WAYW-1:0]           way_o,
	output logic                      hit_q_o
);
	import fetch_pkg::*;

	localparam int AW = $bits(address_t);

	logic [WAYS-1:0] match;

	// A way matches on an equal tag, but only while its line is valid
	always_comb begin
		for (int w = 0; w < WAYS; w++)
			match[w] = valid_i[w] && (tags_i[w] == adr_i[AW-1:HIBIT+1]);
	end

	// Lowest matching way wins
	// Refill never places one line in two ways, so more than one match is not expected
	always_comb begin
		hit_o = 1'b0;
		way_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (match[w] && !hit_o) begin
				hit_o = 1'b1;
				way_o = WAYW'(w);
			end
		end
	end

	// Registered copy lines up with the data leaving the SRAM
	always_ff @(posedge clk) begin
		if (ce_i)
			hit_q_o <= hit_o;
	end

endmodule

// File: rtl/icache_bank.sv
`timescale 1ns/1ps

module icache_bank #(
	parameter int WAYS  = 4,
	parameter int LINES = 16,
	parameter int LOBIT = 5
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce_i,
	input  fetch_pkg::address_t    adr_i,
	input  cache_maint_pkg::fill_t fill_i,
	input  logic                   inv_line_i,
	input  logic                   inv_all_i,
	input  fetch_pkg::address_t    inv_adr_i,
	input  logic                   snoop_i,
	input  fetch_pkg::address_t    snoop_adr_i,
	output logic                   hit_o,
	output logic                   hit_q_o,
	output fetch_pkg::half_line_t  data_o
);
	import fetch_pkg::*;

	localparam int AW    = $bits(address_t);
	localparam int WAYW  = $clog2(WAYS);
	localparam int NDXW  = $clog2(LINES);
	localparam int HIBIT = LOBIT + NDXW - 1;
	localparam int TAGW  = AW - HIBIT - 1;

	// Valid bits, one per way in every set
	logic [LINES-1:0][WAYS-1:0] valid;

	logic [WAYS-1:0][TAGW-1:0] tags;
	logic [WAYS-1:0][TAGW-1:0] stags;
	logic [NDXW-1:0]           ndx;
	logic [NDXW-1:0]           sndx;
	logic [WAYW-1:0]           hit_way;

	// The top level already chose the half-line address, so the set is taken as is
	assign ndx  = adr_i[HIBIT:LOBIT];
	assign sndx = snoop_adr_i[HIBIT:LOBIT];

	tag_array #(.WAYS(WAYS), .LINES(LINES), .LOBIT(LOBIT)) tag_array_inst (
		.clk     (clk),
		.wr_i    (fill_i.wr),
		.way_i   (fill_i.way),
		.wadr_i  (fill_i.adr),
		.ndx_i   (ndx),
		.sndx_i  (sndx),
		.tags_o  (tags),
		.stags_o (stags)
	);

	way_hit #(.WAYS(WAYS), .LINES(LINES), .LOBIT(LOBIT)) way_hit_inst (
		.clk     (clk),
		.ce_i    (ce_i),
		.adr_i   (adr_i),
		.tags_i  (tags),
		.valid_i (valid[ndx]),
		.hit_o   (hit_o),
		.way_o   (hit_way),
		.hit_q_o (hit_q_o)
	);

	// Data is read at the hitting way, on a miss the word is junk and hit_q_o says so
	line_sram #(.WID($bits(half_line_t)), .DEP(WAYS * LINES)) line_sram_inst (
		.clk     (clk),
		.ce_i    (ce_i),
		.wr_i    (fill_i.wr),
		.wadr_i  ({fill_i.way, fill_i.adr[HIBIT:LOBIT]}),
		.radr_i  ({hit_way, ndx}),
		.wdata_i (fill_i.data),
		.rdata_o (data_o)
	);

	// ==============================
	// Valid bit maintenance
	// ==============================

	// Later assignments win, so a fill overrides an invalidate of the same bit
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else begin
			if (inv_all_i)
				valid <= '0;
			else if (inv_line_i)
				valid[inv_adr_i[HIBIT:LOBIT]] <= '0;
			// Snoop drops only the ways that really hold the written line
			if (snoop_i) begin
				for (int w = 0; w < WAYS; w++) begin
					if (stags[w] == snoop_adr_i[AW-1:HIBIT+1])
						valid[sndx][w] <= 1'b0;
				end
			end
			if (fill_i.wr)
				valid[fill_i.adr[HIBIT:LOBIT]][fill_i.way] <= 1'b1;
		end
	end

endmodule

// File: rtl/icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int         WAYS  = 4,
	parameter int         LINES = 16,
	parameter int         LOBIT = 5,
	parameter logic [5:0] CID   = 6'd0
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      ce_i,
	input  fetch_pkg::address_t       fetch_adr_i,
	input  cache_maint_pkg::fill_t    fill_i,
	input  cache_maint_pkg::inv_cmd_t inv_i,
	input  cache_maint_pkg::snoop_t   snoop_i,
	output fetch_pkg::fetch_rsp_t     rsp_o,
	output logic                      miss_o,
	output fetch_pkg::address_t       miss_adr_o
);
	import fetch_pkg::*;
	import cache_maint_pkg::*;

	localparam int AW = $bits(address_t);
	// Width of the line number, everything above the parity bit
	localparam int LW = AW - LOBIT;

	logic [LW-1:0] fetch_line;
	logic          fetch_par;
	address_t      even_adr;
	address_t      odd_adr;
	fill_t         fill_even;
	fill_t         fill_odd;
	logic          inv_line;
	logic          inv_all;
	logic          snoop_ext;
	logic          even_hit;
	logic          odd_hit;
	logic          even_hit_q;
	logic          odd_hit_q;
	half_line_t    even_data;
	half_line_t    odd_data;
	address_t      adr_q;
	logic          rsp_v_q;
	logic [LW-1:0] line_q;
	logic          par_q;

	// ==============================
	// Bank addressing and routing
	// ==============================

	assign fetch_line = fetch_adr_i[AW-1:LOBIT];
	assign fetch_par  = fetch_adr_i[LOBIT-1];

	// An odd fetch needs the even half of the following line
	assign even_adr = {fetch_line + LW'(fetch_par), 1'b0, {(LOBIT-1){1'b0}}};
	assign odd_adr  = {fetch_line, 1'b1, {(LOBIT-1){1'b0}}};

	// The fill goes to one bank only, picked by its parity bit
	always_comb begin
		fill_even    = fill_i;
		fill_odd     = fill_i;
		fill_even.wr = fill_i.wr && !fill_i.adr[LOBIT-1];
		fill_odd.wr  = fill_i.wr && fill_i.adr[LOBIT-1];
	end

	always_comb begin
		inv_line = 1'b0;
		inv_all  = 1'b0;
		case (inv_i.op)
			INV_LINE: inv_line = 1'b1;
			INV_ALL:  inv_all  = 1'b1;
			default:  inv_line = 1'b0;
		endcase
	end

	// Stores from this core are already reflected here
	assign snoop_ext = snoop_i.v && (snoop_i.cid != CID);

	icache_bank #(.WAYS(WAYS), .LINES(LINES), .LOBIT(LOBIT)) even_bank_inst (
		.clk(clk), .rst(rst), .ce_i(ce_i), .adr_i(even_adr), .fill_i(fill_even),
		.inv_line_i(inv_line && !inv_i.adr[LOBIT-1]), .inv_all_i(inv_all),
		.inv_adr_i(inv_i.adr), .snoop_i(snoop_ext && !snoop_i.adr[LOBIT-1]),
		.snoop_adr_i(snoop_i.adr), .hit_o(even_hit), .hit_q_o(even_hit_q),
		.data_o(even_data)
	);

	icache_bank #(.WAYS(WAYS), .LINES(LINES), .LOBIT(LOBIT)) odd_bank_inst (
		.clk(clk), .rst(rst), .ce_i(ce_i), .adr_i(odd_adr), .fill_i(fill_odd),
		.inv_line_i(inv_line && inv_i.adr[LOBIT-1]), .inv_all_i(inv_all),
		.inv_adr_i(inv_i.adr), .snoop_i(snoop_ext && snoop_i.adr[LOBIT-1]),
		.snoop_adr_i(snoop_i.adr), .hit_o(odd_hit), .hit_q_o(odd_hit_q),
		.data_o(odd_data)
	);

	// ==============================
	// Response
	// ==============================

	// Keeps the hit low until a first fetch has been captured after reset
	always_ff @(posedge clk) begin
		if (rst)
			rsp_v_q <= 1'b0;
		else if (ce_i)
			rsp_v_q <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (ce_i)
			adr_q <= fetch_adr_i;
	end

	assign line_q = adr_q[AW-1:LOBIT];
	assign par_q  = adr_q[LOBIT-1];

	// Pair is put in fetch order, addresses come from the registered fetch address
	always_comb begin
		rsp_o.hit = rsp_v_q && even_hit_q && odd_hit_q;
		rsp_o.adr = adr_q;
		if (!par_q) begin
			rsp_o.lo = '{v: rsp_v_q && even_hit_q, data: even_data,
				adr: {line_q, 1'b0, {(LOBIT-1){1'b0}}}};
			rsp_o.hi = '{v: rsp_v_q && odd_hit_q, data: odd_data,
				adr: {line_q, 1'b1, {(LOBIT-1){1'b0}}}};
		end else begin
			rsp_o.lo = '{v: rsp_v_q && odd_hit_q, data: odd_data,
				adr: {line_q, 1'b1, {(LOBIT-1){1'b0}}}};
			rsp_o.hi = '{v: rsp_v_q && even_hit_q, data: even_data,
				adr: {line_q + LW'(1), 1'b0, {(LOBIT-1){1'b0}}}};
		end
	end

	// Even half is reported first, the refill engine asks again for the odd half
	assign miss_o     = !even_hit || !odd_hit;
	assign miss_adr_o = !even_hit ? even_adr : (!odd_hit ? odd_adr : '0);

endmodule

// File: tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
	import fetch_pkg::*;
	import cache_maint_pkg::*;

	localparam string CASE_FILE = "tests/icache_cases.txt";

	logic       clk;
	logic       rst;
	logic       ce;
	address_t   fetch_adr;
	fill_t      fill;
	inv_cmd_t   inv;
	snoop_t     snoop;
	fetch_rsp_t rsp;
	logic       miss;
	address_t   miss_adr;

	// One entry per step of the case file, kept in parallel queues
	string       ops[$];
	string       names[$];
	logic [31:0] adrs[$];
	logic [31:0] args[$];
	logic [31:0] lhs[$];
	logic [31:0] misses[$];
	logic [31:0] madrs[$];
	logic [31:0] d0s[$];
	logic [31:0] d1s[$];

	int n_cases = 0;
	int n_checks = 0;
	int n_errors = 0;
	logic loaded = 1'b0;

	// Expected response of the last fetch, still owed to the next edge
	logic        pend = 1'b0;
	string       pend_name;
	address_t    exp_adr;
	logic [1:0]  exp_lh;
	logic [31:0] exp_d0;
	logic [31:0] exp_d1;

	icache #(.WAYS(4), .LINES(16), .LOBIT(5), .CID(6'd0)) icache_inst (
		.clk         (clk),
		.rst         (rst),
		.ce_i        (ce),
		.fetch_adr_i (fetch_adr),
		.fill_i      (fill),
		.inv_i       (inv),
		.snoop_i     (snoop),
		.rsp_o       (rsp),
		.miss_o      (miss),
		.miss_adr_o  (miss_adr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// Helpers
	// ==============================

	// File words are 32 bits, each half-line repeats its word four times
	function automatic logic [127:0] expand_word(input logic [31:0] w);
		return {4{w}};
	endfunction

	task automatic compare_value(input string name, input string what,
			input logic [127:0] expected, input logic [127:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("ERR %s %s: expected %0h, actual %0h", name, what, expected, actual);
		end
	endtask

	task automatic load_cases();
		int          fd;
		int          code;
		int          n;
		string       line;
		string       op;
		string       name;
		logic [31:0] f [7];
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			n_errors++;
			$display("Could not open the case file %s", CASE_FILE);
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				// Blank lines and lines starting with a hash are skipped
				if (code > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %s %h %h %h %h %h %h %h", op, name,
						f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
					if (n == 9) begin
						ops.push_back(op);
						names.push_back(name);
						adrs.push_back(f[0]);
						args.push_back(f[1]);
						lhs.push_back(f[2]);
						misses.push_back(f[3]);
						madrs.push_back(f[4]);
						d0s.push_back(f[5]);
						d1s.push_back(f[6]);
					end else begin
						n_errors++;
						$display("Case line could not be parsed: %s", line);
					end
				end
			end
			$fclose(fd);
		end
		n_cases = ops.size();
	endtask

	// Lo starts at the half-line holding the fetch address, hi follows 16 bytes on
	task automatic check_response(input string name);
		logic [31:0] lo_adr;
		logic [31:0] hi_adr;
		lo_adr = {exp_adr[31:4], 4'h0};
		hi_adr = lo_adr + 32'd16;
		compare_value(name, "hit", 128'(exp_lh == 2'b11), 128'(rsp.hit));
		compare_value(name, "adr", 128'(exp_adr), 128'(rsp.adr));
		compare_value(name, "lo.v", 128'(exp_lh[1]), 128'(rsp.lo.v));
		compare_value(name, "hi.v", 128'(exp_lh[0]), 128'(rsp.hi.v));
		compare_value(name, "lo.adr", 128'(lo_adr), 128'(rsp.lo.adr));
		compare_value(name, "hi.adr", 128'(hi_adr), 128'(rsp.hi.adr));
		// Data of a missing half-line is not defined
		if (exp_lh[1])
			compare_value(name, "lo.data", expand_word(exp_d0), rsp.lo.data);
		if (exp_lh[0])
			compare_value(name, "hi.data", expand_word(exp_d1), rsp.hi.data);
	endtask

	task automatic clear_inputs();
		ce    = 1'b0;
		fill  = '0;
		inv   = '0;
		snoop = '0;
	endtask

	task automatic drive_step(input int i);
		clear_inputs();
		if (ops[i] == "fill") begin
			fill.wr   = 1'b1;
			fill.way  = args[i][1:0];
			fill.adr  = adrs[i];
			fill.data = expand_word(d0s[i]);
		end else if (ops[i] == "inv") begin
			inv.op  = inv_op_e'(args[i][1:0]);
			inv.adr = adrs[i];
		end else if (ops[i] == "snoop") begin
			snoop.v   = 1'b1;
			snoop.adr = adrs[i];
			snoop.cid = args[i][5:0];
		end else if (ops[i] == "fetch" || ops[i] == "hold") begin
			// A hold moves the address with ce low, so the old answer must stay
			ce        = (ops[i] == "fetch");
			fetch_adr = adrs[i];
			if (ops[i] == "fetch") begin
				exp_adr = adrs[i];
				exp_lh  = lhs[i][1:0];
				exp_d0  = d0s[i];
				exp_d1  = d1s[i];
			end
			pend      = 1'b1;
			pend_name = names[i];
			// Miss outputs follow the address within the same cycle
			#2;
			compare_value(names[i], "miss", 128'(misses[i][0]), 128'(miss));
			compare_value(names[i], "miss_adr", 128'(madrs[i]), 128'(miss_adr));
		end else if (ops[i] != "idle") begin
			n_errors++;
			$display("Unknown operation %s in case %s", ops[i], names[i]);
		end
	endtask

	// ==============================
	// Main sequence and watchdog
	// ==============================

	initial begin
		rst       = 1'b1;
		fetch_adr = '0;
		clear_inputs();
		load_cases();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		// Nothing has been fetched since reset, so no hit may be reported yet
		compare_value("after_reset", "hit", 128'd0, 128'(rsp.hit));
		for (int i = 0; i < n_cases; i++) begin
			@(posedge clk);
			#1;
			if (pend)
				check_response(pend_name);
			pend = 1'b0;
			drive_step(i);
		end
		@(posedge clk);
		#1;
		if (pend)
			check_response(pend_name);
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Each case gets a generous 20 cycles on top of the reset
	initial begin
		wait (loaded);
		repeat (8 + n_cases * 20) @(posedge clk);
		$display("Timeout: the cases did not finish within %0d cycles", 8 + n_cases * 20);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: tests/icache_cases.txt
# Columns: op name adr arg lh miss madr d0 d1, numbers in hex; arg is the way, opcode or cid
# lh is the lo and hi valid pair, madr the miss address, d0 and d1 the fill, lo and hi words
fetch reset_fetch 00001000 0 0 1 00001000 0 0
fill fill_a_even 00001000 0 0 0 0 11110000 0
fill fill_a_odd 00001010 0 0 0 0 11110001 0
fetch par0_hit 00001004 0 3 0 0 11110000 11110001
fetch par1_next_miss 00001018 0 2 1 00001020 11110001 0
fill fill_b_even 00001020 2 0 0 0 22220000 0
fetch par1_hit 00001018 0 3 0 0 11110001 22220000
fetch odd_miss 00001020 0 2 1 00001030 22220000 0
fill fill_c_even 000010a0 1 0 0 0 33330000 0
fill fill_c_odd 000010b0 1 0 0 0 33330001 0
fill fill_d_even 000020a0 3 0 0 0 44440000 0
fill fill_d_odd 000020b0 3 0 0 0 44440001 0
fetch way1_hit 000010a0 0 3 0 0 33330000 33330001
fetch way3_hit 000020a4 0 3 0 0 44440000 44440001
inv inv_line_even 000010a0 1 0 0 0 0 0
fetch inv_d_even 000020a0 0 1 1 000020a0 0 44440001
inv inv_line_odd 000020b0 1 0 0 0 0 0
fetch inv_c_both 000010a8 0 0 1 000010a0 0 0
fetch inv_d_both 000020a0 0 0 1 000020a0 0 0
fetch other_set_hit 00001004 0 3 0 0 11110000 11110001
inv inv_all 00000000 2 0 0 0 0 0
fetch all_gone_a 00001004 0 0 1 00001000 0 0
fetch all_gone_b 00001018 0 0 1 00001020 0 0
fill fill_e_even 00003000 0 0 0 0 55550000 0
fill fill_e_odd 00003010 0 0 0 0 55550001 0
fetch snoop_before 00003000 0 3 0 0 55550000 55550001
snoop snoop_own 00003010 0 0 0 0 0 0
fetch snoop_own_hit 00003000 0 3 0 0 55550000 55550001
snoop snoop_foreign 00003010 5 0 0 0 0 0
fetch snoop_odd_gone 00003000 0 2 1 00003010 55550000 0
fill fill_f_even 00001000 1 0 0 0 66660000 0
snoop snoop_tag_e 00003000 3 0 0 0 0 0
fetch snoop_even_gone 00003000 0 0 1 00003000 0 0
fetch other_tag_kept 00001000 0 2 1 00001010 66660000 0
hold hold_a 00003000 0 2 1 00003000 66660000 0
hold hold_b 00001018 0 2 1 00001020 66660000 0
idle settle 00000000 0 0 0 0 0 0
fetch after_hold 00001000 0 2 1 00001010 66660000 0

// File: build.f
rtl/fetch_pkg.sv
rtl/cache_maint_pkg.sv
rtl/line_sram.sv
rtl/tag_array.sv
rtl/way_hit.sv
rtl/icache_bank.sv
rtl/icache.sv
tests/icache_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module icache_tb -f build.f

out=$(./obj_dir/Vicache_tb)
echo "$out"

# Pass only when the testbench printed its pass line
echo "$out" | grep -qx "PASS: all tests"
